/* hw/rp_pkg.sv */
package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_PIN_W = 16;  // 14 bit converter on upper pins
  localparam int SAMPLE_W  = 14;
  localparam int BUS_W     = 32;  // address and data
  localparam int EXP_W     = 8;
  localparam int LED_W     = 8;

  // region index sits in addr[22:20]
  localparam int N_REGIONS     = 8;
  localparam int REGION_LSB    = 20;
  localparam int REGION_HK     = 0;
  localparam int REGION_ROUTER = 3;
  localparam int REG_OFS_W     = 20;  // low bits seen by a slave

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [BUS_W-1:0] HK_ID = 32'h5250_0100;  // board id word

  localparam logic [REG_OFS_W-1:0] HK_ID_OFS        = 20'h00000;
  localparam logic [REG_OFS_W-1:0] HK_LOOP_OFS      = 20'h0000C;
  localparam logic [REG_OFS_W-1:0] HK_EXP_P_DIR_OFS = 20'h00010;  // 1 = drive pin
  localparam logic [REG_OFS_W-1:0] HK_EXP_N_DIR_OFS = 20'h00014;
  localparam logic [REG_OFS_W-1:0] HK_EXP_P_OUT_OFS = 20'h00018;
  localparam logic [REG_OFS_W-1:0] HK_EXP_N_OUT_OFS = 20'h0001C;
  localparam logic [REG_OFS_W-1:0] HK_EXP_P_IN_OFS  = 20'h00020;  // read only
  localparam logic [REG_OFS_W-1:0] HK_EXP_N_IN_OFS  = 20'h00024;  // read only
  localparam logic [REG_OFS_W-1:0] HK_LED_OFS       = 20'h00030;

  localparam logic [REG_OFS_W-1:0] RT_SEL_A_OFS   = 20'h00000;
  localparam logic [REG_OFS_W-1:0] RT_SEL_B_OFS   = 20'h00004;
  localparam logic [REG_OFS_W-1:0] RT_CONST_A_OFS = 20'h00008;
  localparam logic [REG_OFS_W-1:0] RT_CONST_B_OFS = 20'h0000C;

  // types
  typedef logic signed [SAMPLE_W-1:0] sample_t;    // two's complement
  typedef logic        [SAMPLE_W-1:0] dac_word_t;  // unsigned, negative slope
  typedef logic        [ADC_PIN_W-1:0] adc_pins_t;
  typedef logic        [BUS_W-1:0]    bus_addr_t;
  typedef logic        [BUS_W-1:0]    bus_data_t;
  typedef logic        [EXP_W-1:0]    exp_t;
  typedef logic        [LED_W-1:0]    led_t;

  typedef enum logic [1:0] {
    ROUTE_ADC_A = 2'd0,
    ROUTE_ADC_B = 2'd1,
    ROUTE_CONST = 2'd2,
    ROUTE_SUM   = 2'd3   // saturated a + b
  } route_sel_t;

endpackage

/* hw/sys_bus_decoder.sv */
`timescale 1ns/1ns

module sys_bus_decoder import rp_pkg::*; (
  input  bus_addr_t            sys_addr_i,
  input  logic                 sys_wen_i,    // one cycle pulse
  input  logic                 sys_ren_i,    // one cycle pulse
  output logic [N_REGIONS-1:0] region_wen_o,
  output logic [N_REGIONS-1:0] region_ren_o,
  input  bus_data_t            hk_rdata_i,
  input  bus_data_t            rt_rdata_i,
  input  logic                 hk_ack_i,
  input  logic                 rt_ack_i,
  output bus_data_t            sys_rdata_o,
  output logic                 sys_ack_o
);

  logic [$clog2(N_REGIONS)-1:0] region_idx;  // addr[22:20]
  logic [N_REGIONS-1:0]         region_cs;   // one-hot select

  //////////////////////////////////////////////////////////////////////
  // strobe fan-out
  //////////////////////////////////////////////////////////////////////

  assign region_idx = sys_addr_i[REGION_LSB +: $clog2(N_REGIONS)];
  assign region_cs  = N_REGIONS'(1) << region_idx;

  assign region_wen_o = region_cs & {N_REGIONS{sys_wen_i}};  // only selected slave sees it
  assign region_ren_o = region_cs & {N_REGIONS{sys_ren_i}};

  //////////////////////////////////////////////////////////////////////
  // read data and ack merge
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (region_idx)
      REGION_HK:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
      end
      REGION_ROUTER:
      begin
        sys_rdata_o = rt_rdata_i;
        sys_ack_o   = rt_ack_i;
      end
      default:
      begin
        // empty region, zero data and ack in the strobe cycle
        sys_rdata_o = '0;
        sys_ack_o   = sys_wen_i | sys_ren_i;
      end
    endcase
  end

  // never more than one region strobe, write and read together included
  always_comb
  begin
    assert ($onehot0({region_wen_o, region_ren_o}))
      else $error("bus decoder strobed more than one region");
  end

endmodule

/* hw/adc_frontend.sv */
`timescale 1ns/1ns

module adc_frontend import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  adc_pins_t adc_dat_a_i,  // raw pins, 2 lsbs reserved
  input  adc_pins_t adc_dat_b_i,
  input  logic      loop_en_i,    // digital loopback from hk
  input  sample_t   loop_a_i,     // routed dac samples
  input  sample_t   loop_b_i,
  output sample_t   adc_a_o,
  output sample_t   adc_b_o
);

  logic [SAMPLE_W-1:0] adc_raw_a;  // pin register, offset binary
  logic [SAMPLE_W-1:0] adc_raw_b;

  // input register, upper 14 bits only
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      adc_raw_a <= '0;
      adc_raw_b <= '0;
    end
    else
    begin
      adc_raw_a <= adc_dat_a_i[ADC_PIN_W-1 -: SAMPLE_W];
      adc_raw_b <= adc_dat_b_i[ADC_PIN_W-1 -: SAMPLE_W];
    end
  end

  // negative slope offset binary -> two's complement, keep msb, flip rest
  assign adc_a_o = loop_en_i ? loop_a_i : {adc_raw_a[SAMPLE_W-1], ~adc_raw_a[SAMPLE_W-2:0]};
  assign adc_b_o = loop_en_i ? loop_b_i : {adc_raw_b[SAMPLE_W-1], ~adc_raw_b[SAMPLE_W-2:0]};

endmodule

/* hw/dac_frontend.sv */
`timescale 1ns/1ns

module dac_frontend import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  sample_t   dac_a_i,      // two's complement from router
  input  sample_t   dac_b_i,
  output dac_word_t dac_dat_a_o,  // to converter pins
  output dac_word_t dac_dat_b_o
);

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end
    else
    begin
      // signed -> unsigned negative slope, same bit trick as the adc side
      dac_dat_a_o <= {dac_a_i[SAMPLE_W-1], ~dac_a_i[SAMPLE_W-2:0]};
      dac_dat_b_o <= {dac_b_i[SAMPLE_W-1], ~dac_b_i[SAMPLE_W-2:0]};
    end
  end

endmodule

/* hw/housekeeping.sv */
`timescale 1ns/1ns

module housekeeping import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      loop_en_o,   // digital loopback
  output led_t      led_o,
  input  exp_t      exp_p_i,     // connector pins, async to us
  input  exp_t      exp_n_i,
  output exp_t      exp_p_o,
  output exp_t      exp_n_o,
  output exp_t      exp_p_oe_o,  // 1 = output
  output exp_t      exp_n_oe_o
);

  logic [REG_OFS_W-1:0] reg_ofs;
  exp_t                 exp_p_in;   // sampled connector inputs
  exp_t                 exp_n_in;

  assign reg_ofs = sys_addr_i[REG_OFS_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_en_o  <= 1'b0;
      led_o      <= '0;
      exp_p_oe_o <= '0;  // all pins input after reset
      exp_n_oe_o <= '0;
      exp_p_o    <= '0;
      exp_n_o    <= '0;
      sys_ack_o  <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every strobe acked next cycle
      if (sys_wen_i)
      begin
        case (reg_ofs)
          HK_LOOP_OFS:      loop_en_o  <= sys_wdata_i[0];
          HK_EXP_P_DIR_OFS: exp_p_oe_o <= sys_wdata_i[EXP_W-1:0];
          HK_EXP_N_DIR_OFS: exp_n_oe_o <= sys_wdata_i[EXP_W-1:0];
          HK_EXP_P_OUT_OFS: exp_p_o    <= sys_wdata_i[EXP_W-1:0];
          HK_EXP_N_OUT_OFS: exp_n_o    <= sys_wdata_i[EXP_W-1:0];
          HK_LED_OFS:       led_o      <= sys_wdata_i[LED_W-1:0];
          default: ;  // id, inputs and holes ignore writes
        endcase
      end
    end
  end

  // read side plus one input register stage
  always_ff @(posedge adc_clk)
  begin
    exp_p_in    <= exp_p_i;
    exp_n_in    <= exp_n_i;
    sys_rdata_o <= '0;
    if (sys_ren_i)
    begin
      case (reg_ofs)
        HK_ID_OFS:        sys_rdata_o <= HK_ID;
        HK_LOOP_OFS:      sys_rdata_o <= BUS_W'(loop_en_o);
        HK_EXP_P_DIR_OFS: sys_rdata_o <= BUS_W'(exp_p_oe_o);
        HK_EXP_N_DIR_OFS: sys_rdata_o <= BUS_W'(exp_n_oe_o);
        HK_EXP_P_OUT_OFS: sys_rdata_o <= BUS_W'(exp_p_o);
        HK_EXP_N_OUT_OFS: sys_rdata_o <= BUS_W'(exp_n_o);
        HK_EXP_P_IN_OFS:  sys_rdata_o <= BUS_W'(exp_p_in);
        HK_EXP_N_IN_OFS:  sys_rdata_o <= BUS_W'(exp_n_in);
        HK_LED_OFS:       sys_rdata_o <= BUS_W'(led_o);
        default: ;        // unmapped, reads zero
      endcase
    end
  end

  // an ack always answers a strobe from the cycle before, never two in a row
  a_ack_has_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i) && !$past(sys_ack_o))
    else $error("housekeeping ack without a single strobe before it");

endmodule

/* hw/signal_router.sv */
`timescale 1ns/1ns

module signal_router import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o,
  input  sample_t   adc_a_i,
  input  sample_t   adc_b_i,
  output sample_t   route_a_o,  // to dac and loopback
  output sample_t   route_b_o
);

  logic [REG_OFS_W-1:0] reg_ofs;
  route_sel_t           sel_a, sel_b;
  sample_t              const_a, const_b;
  logic signed [SAMPLE_W:0] sum_ab;  // one guard bit
  sample_t              sum_sat;

  assign reg_ofs = sys_addr_i[REG_OFS_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      sel_a     <= ROUTE_ADC_A;
      sel_b     <= ROUTE_ADC_A;
      const_a   <= '0;
      const_b   <= '0;
      sys_ack_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i)
      begin
        case (reg_ofs)
          RT_SEL_A_OFS:   sel_a   <= route_sel_t'(sys_wdata_i[$bits(route_sel_t)-1:0]);
          RT_SEL_B_OFS:   sel_b   <= route_sel_t'(sys_wdata_i[$bits(route_sel_t)-1:0]);
          RT_CONST_A_OFS: const_a <= sys_wdata_i[SAMPLE_W-1:0];
          RT_CONST_B_OFS: const_b <= sys_wdata_i[SAMPLE_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // readback, constants sign extended
  always_ff @(posedge adc_clk)
  begin
    sys_rdata_o <= '0;
    if (sys_ren_i)
    begin
      case (reg_ofs)
        RT_SEL_A_OFS:   sys_rdata_o <= BUS_W'(sel_a);
        RT_SEL_B_OFS:   sys_rdata_o <= BUS_W'(sel_b);
        RT_CONST_A_OFS: sys_rdata_o <= {{(BUS_W-SAMPLE_W){const_a[SAMPLE_W-1]}}, const_a};
        RT_CONST_B_OFS: sys_rdata_o <= {{(BUS_W-SAMPLE_W){const_b[SAMPLE_W-1]}}, const_b};
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  assign sum_ab = adc_a_i + adc_b_i;
  // guard bit disagrees with msb -> clip to full scale of the sign
  assign sum_sat = (sum_ab[SAMPLE_W] != sum_ab[SAMPLE_W-1])
                   ? {sum_ab[SAMPLE_W], {(SAMPLE_W-1){~sum_ab[SAMPLE_W]}}}
                   : sum_ab[SAMPLE_W-1:0];

  function automatic sample_t route_pick(route_sel_t sel, sample_t cst);
    case (sel)
      ROUTE_ADC_A: return adc_a_i;
      ROUTE_ADC_B: return adc_b_i;
      ROUTE_CONST: return cst;
      default:     return sum_sat;
    endcase
  endfunction

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      route_a_o <= '0;
      route_b_o <= '0;
    end
    else
    begin
      route_a_o <= route_pick(sel_a, const_a);  // one cycle of the 3 cycle path
      route_b_o <= route_pick(sel_b, const_b);
    end
  end

  // strobe answered on the next edge, master quiet while the ack is out
  a_strobe_acked: assert property (@(posedge adc_clk) disable iff (reset_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o && !(sys_wen_i || sys_ren_i))
    else $error("router strobe without ack or strobe during ack");

endmodule

/* hw/rp_top.sv */
`timescale 1ns/1ns

module rp_top import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  // converters
  input  adc_pins_t adc_dat_a_i,
  input  adc_pins_t adc_dat_b_i,
  output dac_word_t dac_dat_a_o,
  output dac_word_t dac_dat_b_o,
  // expansion connector, split for simulation
  input  exp_t      exp_p_i,
  input  exp_t      exp_n_i,
  output exp_t      exp_p_o,
  output exp_t      exp_n_o,
  output exp_t      exp_p_oe_o,
  output exp_t      exp_n_oe_o,
  output led_t      led_o,
  // system bus
  input  bus_addr_t sys_addr_i,
  input  bus_data_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_data_t sys_rdata_o,
  output logic      sys_ack_o
);

  logic [N_REGIONS-1:0] region_wen, region_ren;
  bus_data_t            hk_rdata, rt_rdata;
  logic                 hk_ack, rt_ack;
  sample_t              adc_a, adc_b;      // converted adc or loopback
  sample_t              route_a, route_b;  // router outputs
  logic                 loop_en;

  //////////////////////////////////////////////////////////////////////
  // bus
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_bus (
    .sys_addr_i   (sys_addr_i), .sys_wen_i  (sys_wen_i),  .sys_ren_i (sys_ren_i),
    .region_wen_o (region_wen), .region_ren_o (region_ren),
    .hk_rdata_i   (hk_rdata),   .rt_rdata_i (rt_rdata),
    .hk_ack_i     (hk_ack),     .rt_ack_i   (rt_ack),
    .sys_rdata_o  (sys_rdata_o), .sys_ack_o (sys_ack_o)
  );

  housekeeping i_hk (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (region_wen[REGION_HK]), .sys_ren_i (region_ren[REGION_HK]),
    .sys_rdata_o (hk_rdata), .sys_ack_o (hk_ack),
    .loop_en_o (loop_en), .led_o (led_o),
    .exp_p_i (exp_p_i), .exp_n_i (exp_n_i), .exp_p_o (exp_p_o), .exp_n_o (exp_n_o),
    .exp_p_oe_o (exp_p_oe_o), .exp_n_oe_o (exp_n_oe_o)
  );

  // analog path, adc -> router -> dac, 3 cycles
  adc_frontend i_adc (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i (loop_en), .loop_a_i (route_a), .loop_b_i (route_b),
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  signal_router i_router (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (region_wen[REGION_ROUTER]), .sys_ren_i (region_ren[REGION_ROUTER]),
    .sys_rdata_o (rt_rdata), .sys_ack_o (rt_ack),
    .adc_a_i (adc_a), .adc_b_i (adc_b), .route_a_o (route_a), .route_b_o (route_b)
  );

  dac_frontend i_dac (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .dac_a_i (route_a), .dac_b_i (route_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* test/tb_rp_top.sv */
`timescale 1ns/1ns

module tb_rp_top import rp_pkg::*; ();

  localparam int N_STREAM    = 200;  // samples in the plain routing run
  localparam int N_ROUNDS    = 8;    // random route setups
  localparam int N_ROUND_SMP = 40;
  localparam int N_ACCESS    = 220;  // bus accesses of all tests, rounded up
  localparam int ACCESS_CYC  = 6;    // strobe, ack, idle plus margin
  localparam int RUN_CYC     = 16 + N_ACCESS * ACCESS_CYC + (N_STREAM + 3)
                               + N_ROUNDS * (N_ROUND_SMP + 3) + 40;
  localparam int WATCHDOG_NS = 2 * RUN_CYC * 10;
  localparam int S_MAX       = 2**(SAMPLE_W-1) - 1;
  localparam int S_MIN       = -(2**(SAMPLE_W-1));

  logic      adc_clk;
  logic      reset_i;
  adc_pins_t adc_dat_a_i, adc_dat_b_i;
  dac_word_t dac_dat_a_o, dac_dat_b_o;
  exp_t      exp_p_i, exp_n_i, exp_p_o, exp_n_o, exp_p_oe_o, exp_n_oe_o;
  led_t      led_o;
  bus_addr_t sys_addr_i;
  bus_data_t sys_wdata_i, sys_rdata_o;
  logic      sys_wen_i, sys_ren_i, sys_ack_o;

  int errors, checks, test_errors;

  // register mirror, updated only by what the testbench writes
  logic       loop_m;
  exp_t       dir_p_m, dir_n_m, out_p_m, out_n_m, in_p_m, in_n_m;
  led_t       led_m;
  route_sel_t sel_a_m, sel_b_m;
  sample_t    const_a_m, const_b_m;

  rp_top i_dut (
    .adc_clk (adc_clk), .reset_i (reset_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o),
    .exp_p_i (exp_p_i), .exp_n_i (exp_n_i), .exp_p_o (exp_p_o), .exp_n_o (exp_n_o),
    .exp_p_oe_o (exp_p_oe_o), .exp_n_oe_o (exp_n_oe_o), .led_o (led_o),
    .sys_addr_i (sys_addr_i), .sys_wdata_i (sys_wdata_i),
    .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o)
  );

  always #5 adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sample(input string what, input dac_word_t got, input dac_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_exp(input string what, input exp_t got, input exp_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // model of the analog path
  //////////////////////////////////////////////////////////////////////

  // code 0 is positive full scale, slope -1 per code
  function automatic int adc_value(adc_pins_t pins);
    return S_MAX - int'(pins[ADC_PIN_W-1 -: SAMPLE_W]);
  endfunction

  function automatic dac_word_t dac_code(int v);
    return dac_word_t'(S_MAX - v);  // same negative slope on the way out
  endfunction

  function automatic int saturate(int v);
    if (v > S_MAX)
      return S_MAX;
    if (v < S_MIN)
      return S_MIN;
    return v;
  endfunction

  function automatic dac_word_t predict_dac(route_sel_t sel, sample_t cst,
                                            adc_pins_t pa, adc_pins_t pb);
    int v;
    case (sel)
      ROUTE_ADC_A: v = adc_value(pa);
      ROUTE_ADC_B: v = adc_value(pb);
      ROUTE_CONST: v = int'(cst);
      default:     v = saturate(adc_value(pa) + adc_value(pb));
    endcase
    return dac_code(v);
  endfunction

  // extreme pins sit near either full scale so sums clip
  function automatic adc_pins_t random_pins(bit extreme);
    logic [1:0] hi;
    if (!extreme)
      return adc_pins_t'($urandom);
    hi = $urandom_range(0, 1) ? 2'b11 : 2'b00;
    return {hi, 14'($urandom)};
  endfunction

  function automatic bus_addr_t reg_addr(int region, logic [REG_OFS_W-1:0] ofs);
    return (bus_addr_t'(region) << REGION_LSB) | bus_addr_t'(ofs);
  endfunction

  function automatic bus_data_t sext(sample_t s);
    return bus_data_t'(int'(s));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata, input logic wr,
                            output bus_data_t rdata);
    int         lat;
    int         exp_lat;
    logic       got;
    logic [2:0] region;
    region  = addr[REGION_LSB +: 3];
    exp_lat = (int'(region) == REGION_HK || int'(region) == REGION_ROUTER) ? 1 : 0;
    lat     = 0;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    #1;
    got = sys_ack_o;  // empty regions answer right away
    while (!got && lat < 4)
    begin
      @(negedge adc_clk);
      sys_wen_i = 1'b0;  // strobe is a single cycle
      sys_ren_i = 1'b0;
      #1;
      lat++;
      got = sys_ack_o;
    end
    rdata = sys_rdata_o;
    if (!got)
    begin
      errors++;
      $display("bus access to %h got no acknowledge within 4 cycles", addr);
    end
    else if (lat != exp_lat)
    begin
      errors++;
      $display("bus access to %h was acknowledged after %0d cycles instead of %0d",
               addr, lat, exp_lat);
    end
    @(negedge adc_clk);  // idle cycle before the next strobe
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    bus_data_t unused;
    bus_access(addr, data, 1'b1, unused);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    bus_access(addr, '0, 1'b0, data);
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_data_t exp, input string what);
    bus_data_t rd;
    bus_read(addr, rd);
    check_data(what, rd, exp);
  endtask

  task automatic configure_route(input route_sel_t sa, input route_sel_t sb,
                                 input sample_t ca, input sample_t cb);
    bus_write(reg_addr(REGION_ROUTER, RT_SEL_A_OFS), bus_data_t'(sa));
    bus_write(reg_addr(REGION_ROUTER, RT_SEL_B_OFS), bus_data_t'(sb));
    bus_write(reg_addr(REGION_ROUTER, RT_CONST_A_OFS), sext(ca));
    bus_write(reg_addr(REGION_ROUTER, RT_CONST_B_OFS), sext(cb));
    sel_a_m   = sa;
    sel_b_m   = sb;
    const_a_m = ca;
    const_b_m = cb;
  endtask

  // every readable register against the mirror
  task automatic check_registers();
    read_check(reg_addr(REGION_HK, HK_ID_OFS), HK_ID, "id");
    read_check(reg_addr(REGION_HK, HK_LOOP_OFS), bus_data_t'(loop_m), "loopback");
    read_check(reg_addr(REGION_HK, HK_EXP_P_DIR_OFS), bus_data_t'(dir_p_m), "exp p dir");
    read_check(reg_addr(REGION_HK, HK_EXP_N_DIR_OFS), bus_data_t'(dir_n_m), "exp n dir");
    read_check(reg_addr(REGION_HK, HK_EXP_P_OUT_OFS), bus_data_t'(out_p_m), "exp p out");
    read_check(reg_addr(REGION_HK, HK_EXP_N_OUT_OFS), bus_data_t'(out_n_m), "exp n out");
    read_check(reg_addr(REGION_HK, HK_LED_OFS), bus_data_t'(led_m), "led");
    read_check(reg_addr(REGION_ROUTER, RT_SEL_A_OFS), bus_data_t'(sel_a_m), "sel a");
    read_check(reg_addr(REGION_ROUTER, RT_SEL_B_OFS), bus_data_t'(sel_b_m), "sel b");
    read_check(reg_addr(REGION_ROUTER, RT_CONST_A_OFS), sext(const_a_m), "const a");
    read_check(reg_addr(REGION_ROUTER, RT_CONST_B_OFS), sext(const_b_m), "const b");
  endtask

  // pins driven at one falling edge show up on the dac 3 falling edges later
  task automatic run_stream(input int n, input bit extreme);
    adc_pins_t hist_a[$];
    adc_pins_t hist_b[$];
    adc_pins_t pa, pb;
    for (int i = 0; i < n + 3; i++)
    begin
      @(negedge adc_clk);
      if (i >= 3)
      begin
        pa = hist_a.pop_front();
        pb = hist_b.pop_front();
        check_sample("dac a", dac_dat_a_o, predict_dac(sel_a_m, const_a_m, pa, pb));
        check_sample("dac b", dac_dat_b_o, predict_dac(sel_b_m, const_b_m, pa, pb));
      end
      if (i < n)
      begin
        adc_dat_a_i = random_pins(extreme);
        adc_dat_b_i = random_pins(extreme);
        hist_a.push_back(adc_dat_a_i);
        hist_b.push_back(adc_dat_b_i);
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    sample_t ca, cb;
    bus_data_t rd;
    void'($urandom(32'h7370512e));
    adc_clk = 1'b0;
    reset_i = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    exp_p_i = '0;
    exp_n_i = '0;
    sys_addr_i = '0;
    sys_wdata_i = '0;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    errors = 0;
    checks = 0;
    test_errors = 0;
    loop_m = 1'b0;
    {dir_p_m, dir_n_m, out_p_m, out_n_m, led_m} = '0;
    sel_a_m = ROUTE_ADC_A;  // reset value of both selects
    sel_b_m = ROUTE_ADC_A;
    const_a_m = '0;
    const_b_m = '0;
    repeat (16) @(posedge adc_clk);
    @(negedge adc_clk);
    reset_i = 1'b0;

    // 1. reset values
    check_exp("exp p oe", exp_p_oe_o, '0);
    check_exp("exp n oe", exp_n_oe_o, '0);
    check_exp("led", led_o, '0);
    check_registers();
    end_test(1, "reset values");

    // 2. straight routing
    configure_route(ROUTE_ADC_A, ROUTE_ADC_B, '0, '0);
    run_stream(N_STREAM, 1'b0);
    end_test(2, "adc to dac");

    // 3. random routes, odd rounds force the clipping sum
    for (int r = 0; r < N_ROUNDS; r++)
    begin
      configure_route(r[0] ? ROUTE_SUM : route_sel_t'($urandom_range(0, 3)),
                      route_sel_t'($urandom_range(0, 3)),
                      sample_t'($urandom), sample_t'($urandom));
      read_check(reg_addr(REGION_ROUTER, RT_SEL_A_OFS), bus_data_t'(sel_a_m), "sel a");
      read_check(reg_addr(REGION_ROUTER, RT_CONST_B_OFS), sext(const_b_m), "const b");
      run_stream(N_ROUND_SMP, r[0]);
    end
    end_test(3, "random routing");

    // 4. leds and expansion connector
    for (int r = 0; r < 4; r++)
    begin
      led_m   = led_t'($urandom);
      dir_p_m = exp_t'($urandom);
      dir_n_m = exp_t'($urandom);
      out_p_m = exp_t'($urandom);
      out_n_m = exp_t'($urandom);
      bus_write(reg_addr(REGION_HK, HK_LED_OFS), bus_data_t'(led_m));
      bus_write(reg_addr(REGION_HK, HK_EXP_P_DIR_OFS), bus_data_t'(dir_p_m));
      bus_write(reg_addr(REGION_HK, HK_EXP_N_DIR_OFS), bus_data_t'(dir_n_m));
      bus_write(reg_addr(REGION_HK, HK_EXP_P_OUT_OFS), bus_data_t'(out_p_m));
      bus_write(reg_addr(REGION_HK, HK_EXP_N_OUT_OFS), bus_data_t'(out_n_m));
      @(negedge adc_clk);
      in_p_m  = exp_t'($urandom);
      in_n_m  = exp_t'($urandom);
      exp_p_i = in_p_m;
      exp_n_i = in_n_m;
      check_exp("led pins", led_o, led_m);
      check_exp("exp p oe", exp_p_oe_o, dir_p_m);
      check_exp("exp n oe", exp_n_oe_o, dir_n_m);
      check_exp("exp p out", exp_p_o, out_p_m);
      check_exp("exp n out", exp_n_o, out_n_m);
      read_check(reg_addr(REGION_HK, HK_EXP_P_IN_OFS), bus_data_t'(in_p_m), "exp p in");
      read_check(reg_addr(REGION_HK, HK_EXP_N_IN_OFS), bus_data_t'(in_n_m), "exp n in");
      check_registers();
    end
    end_test(4, "leds and expansion");

    // 5. loopback holds the constant once a reads its own output
    ca = sample_t'($urandom);
    cb = sample_t'($urandom);
    configure_route(ROUTE_CONST, ROUTE_CONST, ca, cb);
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'd1);
    loop_m = 1'b1;
    bus_write(reg_addr(REGION_ROUTER, RT_SEL_A_OFS), bus_data_t'(ROUTE_ADC_A));
    sel_a_m = ROUTE_ADC_A;
    for (int i = 0; i < 12; i++)
    begin
      @(negedge adc_clk);
      check_sample("looped dac a", dac_dat_a_o, dac_code(int'(ca)));
      check_sample("looped dac b", dac_dat_b_o, dac_code(int'(cb)));
      adc_dat_a_i = random_pins(1'b0);  // pins must not matter now
      adc_dat_b_i = random_pins(1'b0);
    end
    check_registers();
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'd0);
    loop_m = 1'b0;
    configure_route(ROUTE_ADC_A, ROUTE_ADC_B, '0, '0);
    end_test(5, "loopback");

    // 6. empty regions
    for (int r = 0; r < N_REGIONS; r++)
    begin
      if (r != REGION_HK && r != REGION_ROUTER)
      begin
        bus_write(reg_addr(r, HK_LED_OFS), bus_data_t'($urandom));
        bus_write(reg_addr(r, RT_SEL_A_OFS), 32'd3);
        read_check(reg_addr(r, HK_LED_OFS), '0, "empty region read");
        bus_read(reg_addr(r, RT_CONST_A_OFS), rd);
        check_data("empty region read", rd, '0);
      end
    end
    check_registers();
    check_exp("led pins", led_o, led_m);
    end_test(6, "empty regions");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // run length bound
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* build.f */
hw/rp_pkg.sv
hw/sys_bus_decoder.sv
hw/adc_frontend.sv
hw/dac_frontend.sv
hw/housekeeping.sv
hw/signal_router.sv
hw/rp_top.sv
test/tb_rp_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the rp_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_top -f build.f \
  --Mdir obj_dir -o tb_rp_top

./obj_dir/tb_rp_top | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
